// File: Bender.yml
package:
  name: ice_bus

sources:
  - src/ice_pkg.sv
  - src/ice_frame_decode.sv
  - src/ice_basics_int.sv
  - src/ice_gpio_int.sv
  - src/ice_bus_result.sv
  - src/ice_bus.sv
  - target: test
    files:
      - dv/ice_bus_tb.sv

// File: dv/ice_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ice_bus_tb;
	import ice_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 5;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 2000;
	localparam int FRAME_TIMEOUT = 500;
	localparam logic [31:0] LFSR_SEED = 32'hd1a2_0b9e;

	logic clk;
	logic reset;
	logic [7:0] rx_char;
	logic rx_char_valid;
	logic [7:0] tx_char;
	logic tx_char_valid;
	logic tx_char_ready;
	logic [GPIO_WIDTH-1:0] gpio_in;
	logic [GPIO_WIDTH-1:0] gpio_out;
	logic [GPIO_WIDTH-1:0] gpio_oe;

	logic [31:0] lfsr;
	logic [7:0] rx_q[$];
	logic [7:0] frame_bytes[0:5];
	int errors;

	ice_bus i_ice_bus (
		.clk(clk),
		.reset(reset),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.tx_char(tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Taps 32, 22, 2, 1; new bit shifts in at the bottom
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Host transmitter ready, low when both bits are set
	initial begin
		logic b0;
		logic b1;
		tx_char_ready = 1'b1;
		lfsr = LFSR_SEED;
		forever begin
			@(posedge clk);
			#DRIVE_DELAY;
			lfsr = lfsr_next(lfsr);
			b0 = lfsr[0];
			lfsr = lfsr_next(lfsr);
			b1 = lfsr[0];
			tx_char_ready = !(b0 && b1);
		end
	end

	// Host receiver, sampled mid-cycle where valid is settled
	always @(negedge clk) begin
		if (!reset && tx_char_valid)
			rx_q.push_back(tx_char);
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic check_code(input string test, input ice_resp_t exp, input ice_resp_t act);
		if (act !== exp) begin
			$display("** Error [%s] reply code: expected %h, actual %h", test, exp, act);
			errors++;
		end
	endtask

	task automatic check_byte(input string test, input string field, input logic [7:0] exp,
			input logic [7:0] act);
		if (act !== exp) begin
			$display("** Error [%s] %s: expected %h, actual %h", test, field, exp, act);
			errors++;
		end
	endtask

	task automatic check_pins(input string test, input string field,
			input logic [GPIO_WIDTH-1:0] exp, input logic [GPIO_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("** Error [%s] %s: expected %h, actual %h", test, field, exp, act);
			errors++;
		end
	endtask

	task automatic wait_drive();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// One strobe, then one idle cycle
	task automatic send_byte(input logic [7:0] b);
		wait_drive();
		rx_char = b;
		rx_char_valid = 1'b1;
		wait_drive();
		rx_char_valid = 1'b0;
	endtask

	// Payload taken from the low len bytes of word, top byte first
	task automatic send_frame(input logic [7:0] op, input logic [7:0] id, input int len,
			input logic [23:0] word);
		send_byte(op);
		send_byte(id);
		send_byte(8'(len));
		for (int i = len - 1; i >= 0; i--)
			send_byte(word[8*i +: 8]);
	endtask

	task automatic set_pins(input logic [GPIO_WIDTH-1:0] value);
		wait_drive();
		gpio_in = value;
	endtask

	// Pull one whole reply frame off the receive queue
	task automatic get_frame(input string test, output bit ok);
		int waited;
		int flen;
		waited = 0;
		ok = 1'b1;
		while (rx_q.size() < 3 && waited < FRAME_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (rx_q.size() < 3) begin
			$display("Error: [%s] no reply header within %0d cycles", test, FRAME_TIMEOUT);
			errors++;
			ok = 1'b0;
			return;
		end
		flen = rx_q[2];
		if (flen > 3) begin
			$display("Error: [%s] reply length %0d is beyond any known frame", test, flen);
			errors++;
			rx_q.delete();
			ok = 1'b0;
			return;
		end
		while (rx_q.size() < 3 + flen && waited < FRAME_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (rx_q.size() < 3 + flen) begin
			$display("Error: [%s] reply payload incomplete after %0d cycles", test, waited);
			errors++;
			ok = 1'b0;
			return;
		end
		for (int i = 0; i < 3 + flen; i++)
			frame_bytes[i] = rx_q.pop_front();
	endtask

	task automatic check_frame(input string test, input ice_resp_t code, input logic [7:0] id,
			input logic [7:0] len, input logic [23:0] payload);
		int n;
		n = len;
		check_code(test, code, ice_resp_t'(frame_bytes[0]));
		check_byte(test, "event id", id, frame_bytes[1]);
		check_byte(test, "length", len, frame_bytes[2]);
		for (int i = 0; i < n && i < 3; i++)
			check_byte(test, $sformatf("payload byte %0d", i), payload[8*(n-1-i) +: 8],
				frame_bytes[3+i]);
	endtask

	task automatic expect_frame(input string test, input ice_resp_t code, input logic [7:0] id,
			input logic [7:0] len, input logic [23:0] payload);
		bit ok;
		get_frame(test, ok);
		if (ok)
			check_frame(test, code, id, len, payload);
	endtask

	// Nothing may come out for a while
	task automatic expect_quiet(input string test, input int cycles);
		repeat (cycles) @(posedge clk);
		if (rx_q.size() != 0) begin
			$display("Error: [%s] %0d unexpected reply bytes arrived", test, rx_q.size());
			errors++;
			rx_q.delete();
		end
	endtask

	task automatic test_version();
		send_frame(OP_VERSION, 8'h11, 0, 24'h0);
		expect_frame("version", RESP_ACK, 8'h11, 8'd2, {8'h00, VERSION_MAJOR, VERSION_MINOR});
	endtask

	// Top byte as outputs, rest stay inputs
	task automatic test_pin_drive();
		send_frame(OP_GPIO_DIR, 8'h21, 3, 24'hff_0000);
		expect_frame("pin_drive", RESP_ACK, 8'h21, 8'd0, 24'h0);
		send_frame(OP_GPIO_LEVEL, 8'h22, 3, 24'h5a_c3_3c);
		expect_frame("pin_drive", RESP_ACK, 8'h22, 8'd0, 24'h0);
		check_pins("pin_drive", "gpio_oe", 24'hff_0000, gpio_oe);
		check_pins("pin_drive", "gpio_out", 24'h5a_c3_3c, gpio_out);
	endtask

	task automatic test_pin_read();
		set_pins(24'h12_34_56);
		// Let the synchronizer settle
		repeat (5) @(posedge clk);
		send_frame(OP_GPIO_READ, 8'h33, 0, 24'h0);
		expect_frame("pin_read", RESP_ACK, 8'h33, 8'd3, 24'h12_34_56);
	endtask

	task automatic test_unknown_op();
		send_frame(8'h5a, 8'h44, 2, 24'h00_beef);
		expect_frame("unknown_op", RESP_NAK, 8'h44, 8'd0, 24'h0);
		send_frame(OP_VERSION, 8'h45, 0, 24'h0);
		expect_frame("unknown_op", RESP_ACK, 8'h45, 8'd2, {8'h00, VERSION_MAJOR, VERSION_MINOR});
	endtask

	task automatic test_interrupts();
		logic [GPIO_WIDTH-1:0] pins;
		// Pin 0 is an input, pin 20 an output
		send_frame(OP_GPIO_INT, 8'h55, 3, 24'h10_0001);
		expect_frame("interrupts", RESP_ACK, 8'h55, 8'd0, 24'h0);
		pins = gpio_in;
		for (int n = 0; n < 3; n++) begin
			pins = pins ^ 24'h00_0001;
			set_pins(pins);
			expect_frame("interrupts", RESP_EVENT, 8'(n), EVENT_LEN, pins);
		end
		// Disabled input pin
		pins = pins ^ 24'h00_0010;
		set_pins(pins);
		expect_quiet("interrupts", 100);
		// Enabled but driven pin
		pins = pins ^ 24'h10_0000;
		set_pins(pins);
		expect_quiet("interrupts", 100);
	endtask

	// Version query lands while an event frame is going out
	task automatic test_backpressure();
		logic [GPIO_WIDTH-1:0] pins;
		bit ok;
		int seen_evt;
		int seen_ack;
		seen_evt = 0;
		seen_ack = 0;
		pins = gpio_in ^ 24'h00_0001;
		set_pins(pins);
		send_frame(OP_VERSION, 8'h66, 0, 24'h0);
		for (int k = 0; k < 2; k++) begin
			get_frame("backpressure", ok);
			if (ok) begin
				if (ice_resp_t'(frame_bytes[0]) == RESP_EVENT) begin
					seen_evt++;
					check_frame("backpressure", RESP_EVENT, 8'd3, EVENT_LEN, pins);
				end else begin
					seen_ack++;
					check_frame("backpressure", RESP_ACK, 8'h66, 8'd2,
						{8'h00, VERSION_MAJOR, VERSION_MINOR});
				end
			end
		end
		if (seen_evt != 1 || seen_ack != 1) begin
			$display("Error: [backpressure] wanted one event and one version reply, got %0d and %0d",
				seen_evt, seen_ack);
			errors++;
		end
	endtask

	initial begin
		errors = 0;
		reset = 1'b1;
		rx_char = 8'h00;
		rx_char_valid = 1'b0;
		gpio_in = '0;
		repeat (2) @(posedge clk);
		// Release between edges
		#DRIVE_DELAY;
		reset = 1'b0;
		repeat (4) @(posedge clk);
		test_version();
		test_pin_drive();
		test_pin_read();
		test_unknown_op();
		test_interrupts();
		test_backpressure();
		expect_quiet("end", 50);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: ice_bus.f
src/ice_pkg.sv
src/ice_frame_decode.sv
src/ice_basics_int.sv
src/ice_gpio_int.sv
src/ice_bus_result.sv
src/ice_bus.sv
dv/ice_bus_tb.sv

// File: src/ice_basics_int.sv
`timescale 1ns/1ps
`default_nettype none

module ice_basics_int (
	input wire clk,
	input wire reset,
	input wire ice_pkg::ma_bus_t ma,
	input wire generate_nak,
	input wire [ice_pkg::GPIO_WIDTH-1:0] gpio_read,
	output ice_pkg::gpio_cfg_t gpio_cfg,
	output ice_pkg::sl_out_t sl,
	input wire grant
);
	import ice_pkg::*;

	logic [GPIO_WIDTH-1:0] shift_q;
	logic [GPIO_WIDTH-1:0] shift_d;
	logic [7:0] pay_cnt;
	logic last_beat;
	logic fv_q;
	logic frame_end;
	logic nak_seen;
	logic [5:0][7:0] reply_q;
	logic [5:0][7:0] reply_d;
	logic [1:0] plen_d;
	logic [1:0] plen_q;
	logic [2:0] idx;
	logic request_q;

	// Payload arrives MSB first
	assign shift_d = {shift_q[GPIO_WIDTH-9:0], ma.data};
	assign last_beat = ma.data_valid && (pay_cnt == ma.len - 8'd1);
	assign frame_end = fv_q && !ma.frame_valid;

	always_ff @(posedge clk) begin
		if (ma.data_valid)
			shift_q <= shift_d;
	end

	// Reply contents as of frame end
	always_comb begin
		plen_d = 2'd0;
		reply_d = '0;
		reply_d[0] = RESP_ACK;
		reply_d[1] = ma.evt_id;
		if (nak_seen) begin
			reply_d[0] = RESP_NAK;
		end else begin
			case (ma.addr)
				OP_VERSION: begin
					plen_d = 2'd2;
					reply_d[3] = VERSION_MAJOR;
					reply_d[4] = VERSION_MINOR;
				end
				OP_GPIO_READ: begin
					// Synchronized pins, top byte first
					plen_d = 2'd3;
					{reply_d[3], reply_d[4], reply_d[5]} = gpio_read;
				end
				// Set commands reply with an empty ACK
				default: plen_d = 2'd0;
			endcase
		end
		reply_d[2] = {6'd0, plen_d};
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			fv_q <= 1'b0;
			pay_cnt <= 8'd0;
			nak_seen <= 1'b0;
			gpio_cfg <= '0;
			request_q <= 1'b0;
			idx <= 3'd0;
			plen_q <= 2'd0;
		end else begin
			fv_q <= ma.frame_valid;
			if (ma.start) begin
				pay_cnt <= 8'd0;
				nak_seen <= generate_nak;
			end else if (ma.data_valid) begin
				pay_cnt <= pay_cnt + 8'd1;
			end
			// Settings take the full word on the last beat
			if (last_beat && ma.len == 8'd3) begin
				case (ma.addr)
					OP_GPIO_LEVEL: gpio_cfg.level <= shift_d;
					OP_GPIO_DIR: gpio_cfg.direction <= shift_d;
					OP_GPIO_INT: gpio_cfg.int_enable <= shift_d;
					default: ;
				endcase
			end
			// Host waits for the reply before its next command
			if (frame_end) begin
				request_q <= 1'b1;
				idx <= 3'd0;
				plen_q <= plen_d;
			end else if (grant) begin
				idx <= idx + 3'd1;
				if (sl.last)
					request_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_end)
			reply_q <= reply_d;
	end

	// Header is three bytes ahead of the payload
	assign sl = '{
		request: request_q,
		data: reply_q[idx],
		last: idx == ({1'b0, plen_q} + 3'd2)
	};

	// Result block only takes from an active requester
	a_grant_needs_req: assert property (@(posedge clk) disable iff (reset)
		grant |-> request_q)
		else $error("grant seen without request");

endmodule

`default_nettype wire

// File: src/ice_bus.sv
`timescale 1ns/1ps
`default_nettype none

module ice_bus (
	input wire clk,
	input wire reset,
	input wire [7:0] rx_char,
	input wire rx_char_valid,
	output logic [7:0] tx_char,
	output logic tx_char_valid,
	input wire tx_char_ready,
	input wire [ice_pkg::GPIO_WIDTH-1:0] gpio_in,
	output logic [ice_pkg::GPIO_WIDTH-1:0] gpio_out,
	output logic [ice_pkg::GPIO_WIDTH-1:0] gpio_oe
);
	import ice_pkg::*;

	ma_bus_t ma;
	logic generate_nak;
	gpio_cfg_t gpio_cfg;
	logic [GPIO_WIDTH-1:0] gpio_sync;
	sl_out_t [NUM_SLAVES-1:0] sl;
	logic [NUM_SLAVES-1:0] grant;
	logic [7:0] global_counter;

	// Host bytes onto the master bus
	ice_frame_decode i_decode (
		.clk(clk),
		.reset(reset),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.ma(ma),
		.generate_nak(generate_nak)
	);

	// Settings, queries and NAKs
	ice_basics_int i_basics (
		.clk(clk),
		.reset(reset),
		.ma(ma),
		.generate_nak(generate_nak),
		.gpio_read(gpio_sync),
		.gpio_cfg(gpio_cfg),
		.sl(sl[SLV_BASICS]),
		.grant(grant[SLV_BASICS])
	);

	// Pads and pin-change events
	ice_gpio_int i_gpio (
		.clk(clk),
		.reset(reset),
		.gpio_cfg(gpio_cfg),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.gpio_sync(gpio_sync),
		.global_counter(global_counter),
		.sl(sl[SLV_GPIO]),
		.grant(grant[SLV_GPIO])
	);

	// Slave bus arbiter and host serializer
	ice_bus_result i_result (
		.clk(clk),
		.reset(reset),
		.sl(sl),
		.grant(grant),
		.tx_char(tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready),
		.global_counter(global_counter)
	);

endmodule

`default_nettype wire

// File: src/ice_bus_result.sv
`timescale 1ns/1ps
`default_nettype none

module ice_bus_result (
	input wire clk,
	input wire reset,
	input wire ice_pkg::sl_out_t [ice_pkg::NUM_SLAVES-1:0] sl,
	output logic [ice_pkg::NUM_SLAVES-1:0] grant,
	output logic [7:0] tx_char,
	output logic tx_char_valid,
	input wire tx_char_ready,
	output logic [7:0] global_counter
);
	import ice_pkg::*;

	logic locked;
	logic fresh;
	logic out_last;
	logic pick_valid;
	logic load;
	logic take;
	logic evt_strobe;
	logic [SLAVE_SEL_W-1:0] owner;
	logic [SLAVE_SEL_W-1:0] pick;
	logic [SLAVE_SEL_W-1:0] sel;
	logic [7:0] out_q;

	// Fixed priority, lowest index wins
	always_comb begin
		pick = '0;
		pick_valid = 1'b0;
		for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
			if (sl[i].request) begin
				pick = SLAVE_SEL_W'(i);
				pick_valid = 1'b1;
			end
		end
	end

	// Stay on the owner until its last byte
	assign sel = locked ? owner : pick;
	assign load = !fresh && (locked ? sl[owner].request : pick_valid);
	// Byte leaves only when the host can accept it
	assign take = fresh && tx_char_ready;
	assign tx_char_valid = take;
	assign tx_char = out_q;
	assign evt_strobe = take && out_last && owner == SLAVE_SEL_W'(SLV_GPIO);

	always_comb begin
		grant = '0;
		if (take)
			grant[owner] = 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			locked <= 1'b0;
			fresh <= 1'b0;
			owner <= '0;
			global_counter <= 8'd0;
		end else begin
			if (take) begin
				fresh <= 1'b0;
				if (out_last)
					locked <= 1'b0;
			end else if (load) begin
				fresh <= 1'b1;
				locked <= 1'b1;
				owner <= sel;
			end
			// One count per event frame sent
			if (evt_strobe)
				global_counter <= global_counter + 8'd1;
		end
	end

	// One-byte output register
	always_ff @(posedge clk) begin
		if (load) begin
			out_q <= sl[sel].data;
			out_last <= sl[sel].last;
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant))
		else $error("more than one grant");

	a_tx_ready: assert property (@(posedge clk) disable iff (reset)
		tx_char_valid |-> tx_char_ready)
		else $error("tx_char_valid while host not ready");

endmodule

`default_nettype wire

// File: src/ice_frame_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ice_frame_decode (
	input wire clk,
	input wire reset,
	input wire [7:0] rx_char,
	input wire rx_char_valid,
	output ice_pkg::ma_bus_t ma,
	output logic generate_nak
);
	import ice_pkg::*;

	typedef enum logic [1:0] {
		ST_OPCODE,
		ST_EVT_ID,
		ST_LEN,
		ST_PAYLOAD
	} dec_state_t;

	dec_state_t state;
	logic [7:0] remain;
	logic frame_valid_q;
	logic data_valid_q;
	logic start_q;
	logic last_q;
	logic [7:0] addr_q;
	logic [7:0] evt_id_q;
	logic [7:0] len_q;
	logic [7:0] data_q;

	function automatic logic is_known_op(input logic [7:0] op);
		case (op)
			OP_VERSION, OP_GPIO_LEVEL, OP_GPIO_DIR, OP_GPIO_INT, OP_GPIO_READ: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Header walk and payload countdown
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_OPCODE;
			remain <= 8'd0;
			frame_valid_q <= 1'b0;
			data_valid_q <= 1'b0;
			start_q <= 1'b0;
			last_q <= 1'b0;
			generate_nak <= 1'b0;
		end else begin
			data_valid_q <= 1'b0;
			start_q <= 1'b0;
			last_q <= 1'b0;
			generate_nak <= 1'b0;
			// Frame closes the cycle after its final beat
			if (last_q)
				frame_valid_q <= 1'b0;
			if (rx_char_valid) begin
				case (state)
					ST_OPCODE: begin
						frame_valid_q <= 1'b1;
						state <= ST_EVT_ID;
					end
					ST_EVT_ID: state <= ST_LEN;
					ST_LEN: begin
						start_q <= 1'b1;
						generate_nak <= !is_known_op(addr_q);
						remain <= rx_char;
						if (rx_char == 8'd0) begin
							// Header-only frame ends on start
							last_q <= 1'b1;
							state <= ST_OPCODE;
						end else begin
							state <= ST_PAYLOAD;
						end
					end
					ST_PAYLOAD: begin
						// Unknown opcodes pass their payload too so framing holds
						data_valid_q <= 1'b1;
						remain <= remain - 8'd1;
						if (remain == 8'd1) begin
							last_q <= 1'b1;
							state <= ST_OPCODE;
						end
					end
					default: state <= ST_OPCODE;
				endcase
			end
		end
	end

	// Header fields and payload byte
	always_ff @(posedge clk) begin
		if (rx_char_valid) begin
			case (state)
				ST_OPCODE: addr_q <= rx_char;
				ST_EVT_ID: evt_id_q <= rx_char;
				ST_LEN: len_q <= rx_char;
				default: data_q <= rx_char;
			endcase
		end
	end

	assign ma = '{
		frame_valid: frame_valid_q,
		data_valid: data_valid_q,
		start: start_q,
		addr: addr_q,
		evt_id: evt_id_q,
		len: len_q,
		data: data_q
	};

	// Payload beats stay inside the frame
	a_data_in_frame: assert property (@(posedge clk) disable iff (reset)
		ma.data_valid |-> ma.frame_valid)
		else $error("data_valid outside of frame_valid");

endmodule

`default_nettype wire

// File: src/ice_gpio_int.sv
`timescale 1ns/1ps
`default_nettype none

module ice_gpio_int (
	input wire clk,
	input wire reset,
	input wire ice_pkg::gpio_cfg_t gpio_cfg,
	input wire [ice_pkg::GPIO_WIDTH-1:0] gpio_in,
	output logic [ice_pkg::GPIO_WIDTH-1:0] gpio_out,
	output logic [ice_pkg::GPIO_WIDTH-1:0] gpio_oe,
	output logic [ice_pkg::GPIO_WIDTH-1:0] gpio_sync,
	input wire [7:0] global_counter,
	output ice_pkg::sl_out_t sl,
	input wire grant
);
	import ice_pkg::*;

	logic [GPIO_WIDTH-1:0] sync1;
	logic [GPIO_WIDTH-1:0] sync2;
	logic [GPIO_WIDTH-1:0] prev;
	logic hit;
	logic pending;
	logic rearm;
	logic [2:0] idx;
	logic [7:0] tag_q;
	logic [GPIO_WIDTH-1:0] pins_q;
	logic [7:0] byte_d;

	// Pad drive and 2-flop input synchronizer
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			gpio_out <= '0;
			gpio_oe <= '0;
			sync1 <= '0;
			sync2 <= '0;
			prev <= '0;
		end else begin
			gpio_out <= gpio_cfg.level;
			gpio_oe <= gpio_cfg.direction;
			sync1 <= gpio_in;
			sync2 <= sync1;
			prev <= sync2;
		end
	end

	assign gpio_sync = sync2;

	// Any edge on an enabled input pin
	assign hit = |((sync2 ^ prev) & gpio_cfg.int_enable & ~gpio_cfg.direction);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pending <= 1'b0;
			rearm <= 1'b0;
			idx <= 3'd0;
		end else begin
			// Edge after pins were captured needs a fresh frame
			if (hit && idx != 3'd0)
				rearm <= 1'b1;
			if (grant && sl.last) begin
				idx <= 3'd0;
				pending <= rearm || hit;
				rearm <= 1'b0;
			end else begin
				if (grant)
					idx <= idx + 3'd1;
				if (hit)
					pending <= 1'b1;
			end
		end
	end

	// Tag and pin state frozen when the first byte goes out
	always_ff @(posedge clk) begin
		if (grant && idx == 3'd0) begin
			tag_q <= global_counter;
			pins_q <= sync2;
		end
	end

	always_comb begin
		case (idx)
			3'd0: byte_d = RESP_EVENT;
			3'd1: byte_d = tag_q;
			3'd2: byte_d = EVENT_LEN;
			3'd3: byte_d = pins_q[GPIO_WIDTH-1 -: 8];
			3'd4: byte_d = pins_q[GPIO_WIDTH-9 -: 8];
			3'd5: byte_d = pins_q[7:0];
			default: byte_d = 8'h00;
		endcase
	end

	assign sl = '{
		request: pending,
		data: byte_d,
		last: idx == 3'd5
	};

endmodule

`default_nettype wire

// File: src/ice_pkg.sv
`default_nettype none

package ice_pkg;

	// Pin count of the GPIO header
	localparam int GPIO_WIDTH = 24;

	// Slave bus requesters, lower index wins at frame boundaries
	localparam int NUM_SLAVES = 2;
	localparam int SLAVE_SEL_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
	localparam int SLV_BASICS = 0;
	localparam int SLV_GPIO = 1;

	// Version query answer
	localparam logic [7:0] VERSION_MAJOR = 8'h00;
	localparam logic [7:0] VERSION_MINOR = 8'h04;

	// Payload length of a pin-interrupt event frame
	localparam logic [7:0] EVENT_LEN = 8'd3;

	// Host opcodes, ASCII
	typedef enum logic [7:0] {
		OP_VERSION    = 8'h56,  // 'V'
		OP_GPIO_LEVEL = 8'h4f,  // 'O'
		OP_GPIO_DIR   = 8'h44,  // 'D'
		OP_GPIO_INT   = 8'h49,  // 'I'
		OP_GPIO_READ  = 8'h6f   // 'o'
	} ice_op_t;

	// First byte of every reply frame
	typedef enum logic [7:0] {
		RESP_ACK   = 8'h00,
		RESP_NAK   = 8'h01,
		RESP_EVENT = 8'h02
	} ice_resp_t;

	// One master bus beat from the frame decoder
	typedef struct packed {
		logic       frame_valid;
		logic       data_valid;
		logic       start;
		logic [7:0] addr;
		logic [7:0] evt_id;
		logic [7:0] len;
		logic [7:0] data;
	} ma_bus_t;

	// What a slave presents to the result block
	typedef struct packed {
		logic       request;
		logic [7:0] data;
		logic       last;
	} sl_out_t;

	// Pin settings, direction high means output
	typedef struct packed {
		logic [GPIO_WIDTH-1:0] level;
		logic [GPIO_WIDTH-1:0] direction;
		logic [GPIO_WIDTH-1:0] int_enable;
	} gpio_cfg_t;

endpackage

`default_nettype wire
